/* Bender.yml */
package:
  name: mem_stage

sources:
  - mem_pkg.sv
  - mem_uop_decode.sv
  - mem_rep_engine.sv
  - mem_data_ram.sv
  - mem_result.sv
  - mem_stage_top.sv
  - target: simulation
    files:
      - tb_mem_stage_props.sv
      - tb_mem_stage.sv

/* flist.f */
mem_pkg.sv
mem_uop_decode.sv
mem_rep_engine.sv
mem_data_ram.sv
mem_result.sv
mem_stage_top.sv
tb_mem_stage_props.sv
tb_mem_stage.sv

/* mem_data_ram.sv */
`timescale 1ns/1ns

module mem_data_ram #(
    parameter int ADDR_W = 6
) (
    input  logic                        clk,
    input  logic                        rd_en_i,
    input  logic [ADDR_W-1:0]           rd_addr_i,
    input  logic                        wb_valid_i,
    input  logic [ADDR_W-1:0]           wb_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  wb_data_i,
    output logic [mem_pkg::DATA_W-1:0]  rd_data_o
);
    import mem_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem_q [0:DEPTH-1];
    logic [DATA_W-1:0] rd_data_q;

    // ########################################################################
    // Writeback port
    // ########################################################################

    // Full word per cycle, never refused
    always_ff @(posedge clk) begin
        if (wb_valid_i) begin
            mem_q[wb_addr_i] <= wb_data_i;
        end
    end

    // ########################################################################
    // Read port
    // ########################################################################

    // Sees the array before any write on the same edge
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_q <= mem_q[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

/* mem_pkg.sv */
package mem_pkg;

    // ########################################################################
    // Widths
    // ########################################################################

    parameter int DATA_W = 32;  // Data and address word
    parameter int TAG_W  = 16;  // Instruction tag carried with each item
    parameter int SEG_W  = 16;  // Segment register value

    // ########################################################################
    // Micro-op field encodings
    // ########################################################################

    // Operand size
    typedef enum logic [1:0] {
        OPSIZE_B = 2'd0,  // 1 byte
        OPSIZE_W = 2'd1,  // 2 bytes
        OPSIZE_D = 2'd2   // 4 bytes
    } opsize_e;

    // Operand source
    typedef enum logic [1:0] {
        SRC_REG = 2'd0,
        SRC_SEG = 2'd1,
        SRC_IMM = 2'd2,
        SRC_MEM = 2'd3
    } src_e;

    // Destination kind
    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_REG  = 2'd1,
        DEST_SEG  = 2'd2,
        DEST_MEM  = 2'd3
    } dest_e;

endpackage

/* mem_rep_engine.sv */
`timescale 1ns/1ns

module mem_rep_engine (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        valid_i,
    input  logic                        is_rep_i,
    input  logic                        dir_i,
    input  logic [mem_pkg::DATA_W-1:0]  addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  count_i,
    input  logic [2:0]                  step_i,
    input  logic                        fwd_stall_i,
    output logic                        stall_o,
    output logic                        accept_o,
    output logic                        item_valid_o,
    output logic [mem_pkg::DATA_W-1:0]  item_addr_o,
    output logic                        advance_o
);
    import mem_pkg::*;

    logic              busy_q;   // Execute register occupied
    logic              rep_q;
    logic              dir_q;
    logic [2:0]        step_q;
    logic [DATA_W-1:0] addr_q;
    logic [DATA_W-1:0] cnt_q;    // Items left, including current one

    logic              last_item;
    logic              zero_rep;
    logic              load;
    logic [DATA_W-1:0] step_ext;
    logic [DATA_W-1:0] next_addr;

    // ########################################################################
    // Handshake
    // ########################################################################

    assign last_item = !rep_q || (cnt_q == DATA_W'(1));

    // Hold upstream until the last item leaves
    assign stall_o   = busy_q && (!last_item || fwd_stall_i);
    assign accept_o  = valid_i && !stall_o;

    // REP with nothing to do is taken but never occupies execute
    assign zero_rep  = is_rep_i && (count_i == '0);
    assign load      = accept_o && !zero_rep;

    assign advance_o = busy_q && !fwd_stall_i;

    // ########################################################################
    // String address stepping
    // ########################################################################

    assign step_ext  = DATA_W'(step_q);
    assign next_addr = dir_q ? (addr_q - step_ext) : (addr_q + step_ext);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            rep_q  <= 1'b0;
            cnt_q  <= '0;
        end else if (load) begin
            // Also covers the last item leaving on this edge
            busy_q <= 1'b1;
            rep_q  <= is_rep_i;
            cnt_q  <= count_i;
        end else if (advance_o) begin
            if (last_item) begin
                busy_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - DATA_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q <= addr_i;
            dir_q  <= dir_i;
            step_q <= step_i;
        end else if (advance_o && !last_item) begin
            addr_q <= next_addr;  // Next element of the string
        end
    end

    assign item_valid_o = busy_q;
    assign item_addr_o  = addr_q;

endmodule

/* mem_result.sv */
`timescale 1ns/1ns

module mem_result (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        load_i,
    input  logic                        advance_i,
    input  logic                        item_valid_i,
    input  logic [mem_pkg::DATA_W-1:0]  item_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  rd_data_i,
    input  logic [mem_pkg::DATA_W-1:0]  byte_mask_i,
    input  mem_pkg::src_e               op1_sel_i,
    input  mem_pkg::src_e               op2_sel_i,
    input  logic [mem_pkg::DATA_W-1:0]  reg_i,
    input  logic [mem_pkg::SEG_W-1:0]   seg_i,
    input  logic [mem_pkg::DATA_W-1:0]  imm_i,
    input  logic                        dest_is_reg_i,
    input  logic                        dest_is_seg_i,
    input  logic                        dest_is_mem_i,
    input  logic [mem_pkg::TAG_W-1:0]   tag_i,
    input  logic                        fwd_stall_i,
    output logic                        valid_o,
    output logic [mem_pkg::TAG_W-1:0]   tag_o,
    output logic [mem_pkg::DATA_W-1:0]  mem_addr_o,
    output logic [mem_pkg::DATA_W-1:0]  op1_o,
    output logic [mem_pkg::DATA_W-1:0]  op2_o,
    output logic                        dest_is_reg_o,
    output logic                        dest_is_seg_o,
    output logic                        dest_is_mem_o,
    output logic [mem_pkg::DATA_W-1:0]  dest_addr_o
);
    import mem_pkg::*;

    // Micro-op fields, taken at accept since upstream moves on afterwards
    logic [TAG_W-1:0]  hold_tag;
    src_e              hold_op1_sel;
    src_e              hold_op2_sel;
    logic [DATA_W-1:0] hold_reg;
    logic [SEG_W-1:0]  hold_seg;
    logic [DATA_W-1:0] hold_imm;
    logic [DATA_W-1:0] hold_mask;
    logic [2:0]        hold_dest;  // {mem, seg, reg}

    // Result register
    logic              valid_q;
    logic [TAG_W-1:0]  tag_q;
    logic [DATA_W-1:0] addr_q;
    src_e              op1_sel_q;
    src_e              op2_sel_q;
    logic [DATA_W-1:0] reg_q;
    logic [SEG_W-1:0]  seg_q;
    logic [DATA_W-1:0] imm_q;
    logic [DATA_W-1:0] mask_q;
    logic [2:0]        dest_q;

    logic [DATA_W-1:0] mem_data;

    function automatic logic [DATA_W-1:0] pick_src(
        input src_e              sel,
        input logic [DATA_W-1:0] reg_val,
        input logic [SEG_W-1:0]  seg_val,
        input logic [DATA_W-1:0] imm_val,
        input logic [DATA_W-1:0] mem_val
    );
        case (sel)
            SRC_REG: pick_src = reg_val;
            SRC_SEG: pick_src = DATA_W'(seg_val);  // Zero extended
            SRC_IMM: pick_src = imm_val;
            default: pick_src = mem_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hold_dest <= '0;
        end else if (load_i) begin
            hold_dest <= {dest_is_mem_i, dest_is_seg_i, dest_is_reg_i};
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            hold_tag     <= tag_i;
            hold_op1_sel <= op1_sel_i;
            hold_op2_sel <= op2_sel_i;
            hold_reg     <= reg_i;
            hold_seg     <= seg_i;
            hold_imm     <= imm_i;
            hold_mask    <= byte_mask_i;
        end
    end

    // ########################################################################
    // Result stage, frozen under forward stall
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            dest_q  <= '0;
        end else if (!fwd_stall_i) begin
            valid_q <= item_valid_i;  // Bubble when execute is empty
            if (advance_i) begin
                dest_q <= hold_dest;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            tag_q     <= hold_tag;
            addr_q    <= item_addr_i;
            op1_sel_q <= hold_op1_sel;
            op2_sel_q <= hold_op2_sel;
            reg_q     <= hold_reg;
            seg_q     <= hold_seg;
            imm_q     <= hold_imm;
            mask_q    <= hold_mask;
        end
    end

    // Align loaded word to the byte offset, then trim to size
    assign mem_data = (rd_data_i >> {addr_q[1:0], 3'b000}) & mask_q;

    assign op1_o = pick_src(op1_sel_q, reg_q, seg_q, imm_q, mem_data);
    assign op2_o = pick_src(op2_sel_q, reg_q, seg_q, imm_q, mem_data);

    assign valid_o       = valid_q;
    assign tag_o         = tag_q;
    assign mem_addr_o    = addr_q;
    assign dest_is_reg_o = dest_q[0];
    assign dest_is_seg_o = dest_q[1];
    assign dest_is_mem_o = dest_q[2];
    assign dest_addr_o   = dest_q[2] ? addr_q : '0;

endmodule

/* mem_stage_top.sv */
`timescale 1ns/1ns

module mem_stage_top #(
    parameter int ADDR_W = 6
) (
    input  logic                        clk,
    input  logic                        rst_i,
    // Micro-op in
    input  logic                        valid_i,
    input  mem_pkg::opsize_e            opsize_i,
    input  logic                        is_rep_i,
    input  logic                        dir_i,
    input  logic [mem_pkg::DATA_W-1:0]  addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  count_i,
    input  logic [mem_pkg::DATA_W-1:0]  reg_i,
    input  logic [mem_pkg::SEG_W-1:0]   seg_i,
    input  logic [mem_pkg::DATA_W-1:0]  imm_i,
    input  mem_pkg::src_e               op1_sel_i,
    input  mem_pkg::src_e               op2_sel_i,
    input  mem_pkg::dest_e              dest_sel_i,
    input  logic [mem_pkg::TAG_W-1:0]   tag_i,
    output logic                        stall_o,
    // Writeback
    input  logic                        wb_valid_i,
    input  logic [mem_pkg::DATA_W-1:0]  wb_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  wb_data_i,
    // Item out
    output logic                        valid_o,
    output logic [mem_pkg::TAG_W-1:0]   tag_o,
    output logic [mem_pkg::DATA_W-1:0]  mem_addr_o,
    output logic [mem_pkg::DATA_W-1:0]  op1_o,
    output logic [mem_pkg::DATA_W-1:0]  op2_o,
    output logic                        dest_is_reg_o,
    output logic                        dest_is_seg_o,
    output logic                        dest_is_mem_o,
    output logic [mem_pkg::DATA_W-1:0]  dest_addr_o,
    input  logic                        fwd_stall_i
);
    import mem_pkg::*;

    logic [2:0]        step;
    logic [DATA_W-1:0] byte_mask;
    logic              dec_reg;
    logic              dec_seg;
    logic              dec_mem;
    logic              accept;
    logic              advance;
    logic              item_valid;
    logic [DATA_W-1:0] item_addr;
    logic [DATA_W-1:0] rd_data;

    mem_uop_decode u_decode (
        .opsize_i      (opsize_i),
        .dest_sel_i    (dest_sel_i),
        .step_o        (step),
        .byte_mask_o   (byte_mask),
        .dest_is_reg_o (dec_reg),
        .dest_is_seg_o (dec_seg),
        .dest_is_mem_o (dec_mem)
    );

    mem_rep_engine u_rep_engine (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .is_rep_i     (is_rep_i),
        .dir_i        (dir_i),
        .addr_i       (addr_i),
        .count_i      (count_i),
        .step_i       (step),
        .fwd_stall_i  (fwd_stall_i),
        .stall_o      (stall_o),
        .accept_o     (accept),
        .item_valid_o (item_valid),
        .item_addr_o  (item_addr),
        .advance_o    (advance)
    );

    // Byte addresses to word index
    mem_data_ram #(
        .ADDR_W (ADDR_W)
    ) u_data_ram (
        .clk        (clk),
        .rd_en_i    (advance),
        .rd_addr_i  (item_addr[ADDR_W+1:2]),
        .wb_valid_i (wb_valid_i),
        .wb_addr_i  (wb_addr_i[ADDR_W+1:2]),
        .wb_data_i  (wb_data_i),
        .rd_data_o  (rd_data)
    );

    mem_result u_result (
        .clk           (clk),
        .rst_i         (rst_i),
        .load_i        (accept),
        .advance_i     (advance),
        .item_valid_i  (item_valid),
        .item_addr_i   (item_addr),
        .rd_data_i     (rd_data),
        .byte_mask_i   (byte_mask),
        .op1_sel_i     (op1_sel_i),
        .op2_sel_i     (op2_sel_i),
        .reg_i         (reg_i),
        .seg_i         (seg_i),
        .imm_i         (imm_i),
        .dest_is_reg_i (dec_reg),
        .dest_is_seg_i (dec_seg),
        .dest_is_mem_i (dec_mem),
        .tag_i         (tag_i),
        .fwd_stall_i   (fwd_stall_i),
        .valid_o       (valid_o),
        .tag_o         (tag_o),
        .mem_addr_o    (mem_addr_o),
        .op1_o         (op1_o),
        .op2_o         (op2_o),
        .dest_is_reg_o (dest_is_reg_o),
        .dest_is_seg_o (dest_is_seg_o),
        .dest_is_mem_o (dest_is_mem_o),
        .dest_addr_o   (dest_addr_o)
    );

endmodule

/* mem_uop_decode.sv */
`timescale 1ns/1ns

module mem_uop_decode (
    input  mem_pkg::opsize_e            opsize_i,
    input  mem_pkg::dest_e              dest_sel_i,
    output logic [2:0]                  step_o,
    output logic [mem_pkg::DATA_W-1:0]  byte_mask_o,
    output logic                        dest_is_reg_o,
    output logic                        dest_is_seg_o,
    output logic                        dest_is_mem_o
);
    import mem_pkg::*;

    // Address step and load mask per operand size
    always_comb begin
        case (opsize_i)
            OPSIZE_B: begin
                step_o      = 3'd1;
                byte_mask_o = DATA_W'(32'h0000_00ff);
            end
            OPSIZE_W: begin
                step_o      = 3'd2;
                byte_mask_o = DATA_W'(32'h0000_ffff);
            end
            default: begin  // Dword, unused code treated alike
                step_o      = 3'd4;
                byte_mask_o = '1;
            end
        endcase
    end

    // One-hot destination flags
    always_comb begin
        dest_is_reg_o = 1'b0;
        dest_is_seg_o = 1'b0;
        dest_is_mem_o = 1'b0;
        case (dest_sel_i)
            DEST_REG: dest_is_reg_o = 1'b1;
            DEST_SEG: dest_is_seg_o = 1'b1;
            DEST_MEM: dest_is_mem_o = 1'b1;
            default:  ;  // No destination
        endcase
    end

endmodule

/* tb_mem_stage.sv */
`timescale 1ns/1ns

module tb_mem_stage;
    import mem_pkg::*;

    localparam int ADDR_W     = 6;
    localparam int DEPTH      = 1 << ADDR_W;
    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 200;
    localparam int ITEM_W     = TAG_W + 4 * DATA_W + 3;
    localparam int REP_COUNTS [4] = '{0, 1, 3, 6};
    // Loads, sources, dests, REP sweep plus marker, random micro-ops
    localparam int MAX_ITEMS  = DEPTH * 8 + 16 + 8 + 24 * 6 + 1 + N_RAND * 4;
    localparam int WATCHDOG_CYCLES = 3 + DEPTH + 4 * MAX_ITEMS + 200;

    logic              clk = 1'b0;
    logic              rst_i;
    logic              valid_i;
    opsize_e           opsize_i;
    logic              is_rep_i;
    logic              dir_i;
    logic [DATA_W-1:0] addr_i;
    logic [DATA_W-1:0] count_i;
    logic [DATA_W-1:0] reg_i;
    logic [SEG_W-1:0]  seg_i;
    logic [DATA_W-1:0] imm_i;
    src_e              op1_sel_i;
    src_e              op2_sel_i;
    dest_e             dest_sel_i;
    logic [TAG_W-1:0]  tag_i;
    logic              stall_o;
    logic              wb_valid_i;
    logic [DATA_W-1:0] wb_addr_i;
    logic [DATA_W-1:0] wb_data_i;
    logic              valid_o;
    logic [TAG_W-1:0]  tag_o;
    logic [DATA_W-1:0] mem_addr_o;
    logic [DATA_W-1:0] op1_o;
    logic [DATA_W-1:0] op2_o;
    logic              dest_is_reg_o;
    logic              dest_is_seg_o;
    logic              dest_is_mem_o;
    logic [DATA_W-1:0] dest_addr_o;
    logic              fwd_stall_i;

    logic [15:0]       lfsr = 16'd29300;
    logic [DATA_W-1:0] shadow [0:DEPTH-1];  // Mirror of the data RAM
    logic [ITEM_W-1:0] exp_q [$];
    string             name_q [$];
    logic [TAG_W-1:0]  next_tag;
    logic              stall_en;
    logic              next_stall;
    int                waits;     // Edges the last micro-op spent stalled
    int                prev_cnt;

    mem_stage_top #(
        .ADDR_W (ADDR_W)
    ) u_mem_stage_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] operand(
        input src_e              sel,
        input logic [DATA_W-1:0] loaded
    );
        case (sel)
            SRC_REG: return reg_i;
            SRC_SEG: return DATA_W'(seg_i);
            SRC_IMM: return imm_i;
            default: return loaded;
        endcase
    endfunction

    // Expected item k of the micro-op now on the inputs
    function automatic logic [ITEM_W-1:0] expect_item(input int k);
        int                nbytes;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] loaded;
        logic [2:0]        flags;
        nbytes = (opsize_i == OPSIZE_B) ? 1 : (opsize_i == OPSIZE_W) ? 2 : 4;
        a      = dir_i ? addr_i - DATA_W'(k * nbytes) : addr_i + DATA_W'(k * nbytes);
        loaded = shadow[(a >> 2) % DEPTH] >> (8 * a[1:0]);
        if (nbytes < 4) begin
            loaded = loaded % (DATA_W'(1) << (8 * nbytes));
        end
        flags  = {dest_sel_i == DEST_MEM, dest_sel_i == DEST_SEG, dest_sel_i == DEST_REG};
        return {tag_i, a, operand(op1_sel_i, loaded), operand(op2_sel_i, loaded), flags,
                (dest_sel_i == DEST_MEM) ? a : DATA_W'(0)};
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(
        input string             what,
        input logic [DATA_W-1:0] expected,
        input logic [DATA_W-1:0] actual
    );
        if (expected !== actual) begin
            stop_on_error($sformatf("mismatch in %s: expected %h, actual %h",
                                    what, expected, actual));
        end
    endtask

    // Drive one micro-op and return at its accept edge
    task automatic send_uop(
        input string   name,
        input opsize_e size,
        input logic    rep,
        input logic    dir,
        input int      base,
        input int      cnt,
        input src_e    sel1,
        input src_e    sel2,
        input dest_e   dest
    );
        valid_i    <= 1'b1;
        opsize_i   <= size;
        is_rep_i   <= rep;
        dir_i      <= dir;
        addr_i     <= DATA_W'(base);
        count_i    <= DATA_W'(cnt);
        reg_i      <= rand_bits(32);
        seg_i      <= SEG_W'(rand_bits(16));
        imm_i      <= rand_bits(32);
        op1_sel_i  <= sel1;
        op2_sel_i  <= sel2;
        dest_sel_i <= dest;
        tag_i      <= next_tag;
        waits = 0;
        @(posedge clk);
        while (stall_o) begin
            waits++;
            @(posedge clk);
        end
        for (int k = 0; k < (rep ? cnt : 1); k++) begin  // Zero-count REP pushes nothing
            exp_q.push_back(expect_item(k));
            name_q.push_back(name);
        end
        next_tag++;
    endtask

    // ########################################################################
    // Back-pressure and output comparison
    // ########################################################################

    always @(negedge clk) begin
        next_stall = stall_en && (rand_bits(2) == 32'd3);
    end

    always @(posedge clk) begin
        fwd_stall_i <= next_stall;
    end

    // An item seen here leaves the outputs at the next rising edge
    always @(negedge clk) begin
        logic [TAG_W-1:0]  e_tag;
        logic [DATA_W-1:0] e_addr;
        logic [DATA_W-1:0] e_op1;
        logic [DATA_W-1:0] e_op2;
        logic [2:0]        e_flags;
        logic [DATA_W-1:0] e_daddr;
        string             name;
        if (!rst_i && valid_o && !fwd_stall_i) begin
            if (exp_q.size() == 0) begin
                stop_on_error($sformatf("unexpected item with tag %h on the outputs", tag_o));
            end else begin
                {e_tag, e_addr, e_op1, e_op2, e_flags, e_daddr} = exp_q.pop_front();
                name = name_q.pop_front();
                check_value({name, " tag"}, DATA_W'(e_tag), DATA_W'(tag_o));
                check_value({name, " mem_addr"}, e_addr, mem_addr_o);
                check_value({name, " op1"}, e_op1, op1_o);
                check_value({name, " op2"}, e_op2, op2_o);
                check_value({name, " dest flags"}, DATA_W'(e_flags),
                            DATA_W'({dest_is_mem_o, dest_is_seg_o, dest_is_reg_o}));
                check_value({name, " dest_addr"}, e_daddr, dest_addr_o);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("timeout, the DUT did not deliver all expected items in time");
    end

    // ########################################################################
    // Stimulus
    // ########################################################################

    initial begin
        logic [DATA_W-1:0] data;
        rst_i       = 1'b1;
        valid_i     = 1'b0;
        opsize_i    = OPSIZE_B;
        is_rep_i    = 1'b0;
        dir_i       = 1'b0;
        addr_i      = '0;
        count_i     = '0;
        reg_i       = '0;
        seg_i       = '0;
        imm_i       = '0;
        op1_sel_i   = SRC_REG;
        op2_sel_i   = SRC_REG;
        dest_sel_i  = DEST_NONE;
        tag_i       = '0;
        wb_valid_i  = 1'b0;
        wb_addr_i   = '0;
        wb_data_i   = '0;
        fwd_stall_i = 1'b0;
        next_tag    = '0;
        stall_en    = 1'b0;
        next_stall  = 1'b0;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;

        for (int w = 0; w < DEPTH; w++) begin  // Fill through writeback
            data = rand_bits(32) ^ (DATA_W'(w) * 32'h0101_0101);
            wb_valid_i <= 1'b1;
            wb_addr_i  <= DATA_W'(w * 4);
            wb_data_i  <= data;
            shadow[w]  = data;
            @(posedge clk);
        end
        wb_valid_i <= 1'b0;

        // Every size at every offset that fits the word
        for (int w = 0; w < DEPTH; w++) begin
            for (int sz = 0; sz < 3; sz++) begin
                for (int off = 0; off <= 4 - (1 << sz); off++) begin
                    send_uop("load", opsize_e'(2'(sz)), 1'b0, 1'b0, w * 4 + off, 0,
                             SRC_MEM, SRC_MEM, DEST_REG);
                end
            end
        end

        for (int s1 = 0; s1 < 4; s1++) begin
            for (int s2 = 0; s2 < 4; s2++) begin
                send_uop("source", opsize_e'(2'(rand_bits(2) % 3)), 1'b0, 1'b0,
                         int'(rand_bits(8)), 0, src_e'(2'(s1)), src_e'(2'(s2)), DEST_NONE);
            end
        end

        for (int n = 0; n < 8; n++) begin
            send_uop("dest", OPSIZE_D, 1'b0, 1'b0, int'(rand_bits(8)), 0,
                     SRC_REG, SRC_MEM, dest_e'(2'(n % 4)));
        end

        // REP sweep, no back-pressure so the stall length is exact
        prev_cnt = 0;
        for (int sz = 0; sz < 3; sz++) begin
            for (int d = 0; d < 2; d++) begin
                for (int c = 0; c < 4; c++) begin
                    send_uop("rep", opsize_e'(2'(sz)), 1'b1, 1'(d), 96 + int'(rand_bits(6)),
                             REP_COUNTS[c], SRC_MEM, SRC_IMM, DEST_MEM);
                    check_value("rep stall cycles", DATA_W'(prev_cnt > 1 ? prev_cnt - 1 : 0),
                                DATA_W'(waits));
                    prev_cnt = REP_COUNTS[c];
                end
            end
        end
        send_uop("rep", OPSIZE_B, 1'b0, 1'b0, 16, 0, SRC_REG, SRC_SEG, DEST_NONE);
        check_value("rep stall cycles", DATA_W'(prev_cnt > 1 ? prev_cnt - 1 : 0),
                    DATA_W'(waits));

        stall_en = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            send_uop("random", opsize_e'(2'(rand_bits(2) % 3)), 1'(rand_bits(1)),
                     1'(rand_bits(1)), 64 + int'(rand_bits(7)), int'(rand_bits(3) % 5),
                     src_e'(2'(rand_bits(2))), src_e'(2'(rand_bits(2))),
                     dest_e'(2'(rand_bits(2))));
        end
        stall_en = 1'b0;
        valid_i <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);  // Room for a stray extra item
        if (u_mem_stage_top.u_props.fail_count != 0) begin
            stop_on_error("the property checker reported failed assertions");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* tb_mem_stage_props.sv */
`timescale 1ns/1ns

module tb_mem_stage_props (
    input logic                        clk,
    input logic                        rst_i,
    input logic                        stall_i,
    input logic                        out_valid_i,
    input logic                        fwd_stall_i,
    input logic [mem_pkg::TAG_W-1:0]   tag_i,
    input logic [mem_pkg::DATA_W-1:0]  mem_addr_i,
    input logic [mem_pkg::DATA_W-1:0]  op1_i,
    input logic [mem_pkg::DATA_W-1:0]  op2_i,
    input logic                        dest_reg_i,
    input logic                        dest_seg_i,
    input logic                        dest_mem_i,
    input logic [mem_pkg::DATA_W-1:0]  dest_addr_i
);
    int unsigned fail_count = 0;  // Read by the testbench at the end

    // Handshake idle right after reset
    assert property (@(posedge clk) rst_i |=> !stall_i && !out_valid_i)
        else begin
            $error("stall or valid set in the cycle after reset");
            fail_count++;
        end

    // Item frozen while downstream pushes back
    assert property (@(posedge clk) disable iff (rst_i)
        out_valid_i && fwd_stall_i |=> out_valid_i && $stable(tag_i) && $stable(mem_addr_i)
            && $stable(op1_i) && $stable(op2_i) && $stable(dest_addr_i)
            && $stable({dest_reg_i, dest_seg_i, dest_mem_i}))
        else begin
            $error("output item changed under forward stall");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst_i)
        out_valid_i |-> $onehot0({dest_reg_i, dest_seg_i, dest_mem_i}))
        else begin
            $error("more than one destination flag set");
            fail_count++;
        end

endmodule

bind mem_stage_top tb_mem_stage_props u_props (
    .clk         (clk),
    .rst_i       (rst_i),
    .stall_i     (stall_o),
    .out_valid_i (valid_o),
    .fwd_stall_i (fwd_stall_i),
    .tag_i       (tag_o),
    .mem_addr_i  (mem_addr_o),
    .op1_i       (op1_o),
    .op2_i       (op2_o),
    .dest_reg_i  (dest_is_reg_o),
    .dest_seg_i  (dest_is_seg_o),
    .dest_mem_i  (dest_is_mem_o),
    .dest_addr_i (dest_addr_o)
);
